// File: compile.f
+incdir+hdl
hdl/snake_pkg.sv
hdl/prbs7.sv
hdl/game_control.sv
hdl/steering.sv
hdl/snake_body.sv
hdl/fruit_score.sv
hdl/snake_game.sv
testbench/snake_chk.sv
testbench/snake_monitor.sv
testbench/snake_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = snake_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -- '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/snake_input.txt
# name command count head_x head_y fruit_x fruit_y score length running game_over
# -1 in an expected column means that value is not compared
reset_values   check        0  8  40 18 50  0  6 0 0
start_game     press_right  0  8  40 18 50  0  6 1 0
move_right     tick        10 18  40 18 50  0  6 1 0
turn_down      press_right  0 18  40 18 50  0  6 1 0
eat_fruit      tick        10 18  50 -1 -1  1  7 1 0
fruit_placed   fruit        0 -1  -1 -1 -1 -1 -1 1 0
both_ignored   press_both   0 18  50 -1 -1 -1 -1 1 0
keep_down      tick         1 18  51 -1 -1 -1 -1 1 0
turn_left_1    press_left   0 18  51 -1 -1 -1 -1 1 0
step_right     tick         1 19  51 -1 -1 -1 -1 1 0
turn_left_2    press_left   0 19  51 -1 -1 -1 -1 1 0
step_up        tick         1 19  50 -1 -1 -1 -1 1 0
hit_wall       tick        50 19   0 -1 -1 -1 -1 0 1
restart        press_right  0  8  40 18 50  0  6 0 0
restart_start  press_right  0  8  40 18 50  0  6 1 0

// File: testbench/snake_tb.sv
`timescale 1ns/1ns
`default_nettype none

module snake_tb import snake_pkg::*; ();

    logic   clock_25;
    logic   reset;
    logic   game_tik;
    logic   turn_right;
    logic   turn_left;
    pos_t   head;
    pos_t   fruit;
    score_t score;
    len_t   snake_length;
    logic   running;
    logic   game_over;
    logic   tick_ready;

    string  names[$];
    string  cmds[$];
    int     counts[$];
    int     expect_q[$];        // Eight expected values per line
    int     line_count = 0;
    logic   loaded = 1'b0;

    snake_game dut (
        .clock_25(clock_25),
        .reset(reset),
        .game_tik(game_tik),
        .turn_right(turn_right),
        .turn_left(turn_left),
        .head(head),
        .fruit(fruit),
        .score(score),
        .snake_length(snake_length),
        .running(running),
        .game_over(game_over),
        .tick_ready(tick_ready)
    );

    snake_monitor mon (
        .head(head),
        .fruit(fruit),
        .score(score),
        .snake_length(snake_length),
        .running(running),
        .game_over(game_over),
        .tick_ready(tick_ready)
    );

    bind snake_game snake_chk chk (
        .clock_25(clock_25),
        .reset(reset),
        .running(running),
        .game_over(game_over),
        .tick_ready(tick_ready),
        .head(head),
        .fruit(fruit),
        .score(score)
    );

    always #4 clock_25 = ~clock_25;

    task automatic read_script();
        int    fd;
        int    rc;
        string line;
        string name;
        string cmd;
        int    v[9];
        fd = $fopen("testbench/snake_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/snake_input.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line[0] != "#") begin
                rc = $sscanf(line, "%s %s %d %d %d %d %d %d %d %d %d", name, cmd, v[0], v[1],
                             v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                if (rc == 11) begin
                    names.push_back(name);
                    cmds.push_back(cmd);
                    counts.push_back(v[0]);
                    for (int i = 1; i < 9; i++)
                        expect_q.push_back(v[i]);
                    line_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Button pulse of one cycle, then time for latch and direction to settle
    task automatic press(input logic right, input logic left);
        turn_right = right;
        turn_left  = left;
        @(negedge clock_25);
        turn_right = 1'b0;
        turn_left  = 1'b0;
        repeat (2) @(negedge clock_25);
    endtask

    task automatic run_ticks(input int n);
        for (int k = 0; k < n; k++) begin
            while (!tick_ready && !game_over)
                @(negedge clock_25);
            if (game_over)
                break;
            game_tik = 1'b1;
            @(negedge clock_25);
            game_tik = 1'b0;
            while (!tick_ready && !game_over)   // Step done when tick_ready returns
                @(negedge clock_25);
        end
    endtask

    initial begin
        clock_25   = 1'b0;
        reset      = 1'b0;
        game_tik   = 1'b0;
        turn_right = 1'b0;
        turn_left  = 1'b0;
        read_script();
        loaded = 1'b1;
        repeat (8) @(posedge clock_25);
        @(negedge clock_25);
        reset = 1'b1;
        repeat (2) @(negedge clock_25);

        for (int t = 0; t < line_count; t++) begin
            case (cmds[t])
                "press_right": press(1'b1, 1'b0);
                "press_left":  press(1'b0, 1'b1);
                "press_both":  press(1'b1, 1'b1);
                "tick":        run_ticks(counts[t]);
                default:       ;
            endcase
            if (cmds[t] == "fruit")
                mon.check_fruit(names[t]);
            else if (cmds[t] == "check" || cmds[t] == "tick" || cmds[t].substr(0, 4) == "press")
                mon.check_state(names[t], expect_q[t*8], expect_q[t*8+1], expect_q[t*8+2],
                                expect_q[t*8+3], expect_q[t*8+4], expect_q[t*8+5],
                                expect_q[t*8+6], expect_q[t*8+7]);
            else
                mon.note_failure(names[t], "unknown command in the script");
        end

        $display("Tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 mon.pass_count + mon.fail_count, mon.pass_count, mon.fail_count,
                 dut.chk.assert_fails);
        if (line_count > 0 && mon.fail_count == 0 && dut.chk.assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            if (line_count == 0)
                $display("No tests were read from the script");
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog sized from the script length
    initial begin
        wait (loaded);
        repeat ((line_count + 1) * 200) @(posedge clock_25);
        $display("Timeout: the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/snake_monitor.sv
`timescale 1ns/1ns
`default_nettype none

`include "snake_defines.svh"

module snake_monitor import snake_pkg::*; (
    input pos_t   head,
    input pos_t   fruit,
    input score_t score,
    input len_t   snake_length,
    input logic   running,
    input logic   game_over,
    input logic   tick_ready
);

    int pass_count = 0;
    int fail_count = 0;

    // Negative expected value means no comparison
    task automatic compare_field(input string test, input string field, input int expected,
                                 input int actual, inout int bad);
        if (expected >= 0 && expected != actual) begin
            $display("** Error: %s %s expected %0d actual %0d", test, field, expected, actual);
            bad++;
        end
    endtask

    task automatic finish_test(input string test, input int bad);
        if (bad == 0) begin
            pass_count++;
            $display("[ok]     %s", test);
        end else begin
            fail_count++;
            $display("[failed] %s", test);
        end
    endtask

    task automatic check_state(input string test, input int hx, input int hy, input int fx,
                               input int fy, input int sc, input int ln, input int run,
                               input int over);
        int bad;
        bad = 0;
        compare_field(test, "head.x", hx, int'(head.x), bad);
        compare_field(test, "head.y", hy, int'(head.y), bad);
        compare_field(test, "fruit.x", fx, int'(fruit.x), bad);
        compare_field(test, "fruit.y", fy, int'(fruit.y), bad);
        compare_field(test, "score", sc, int'(score), bad);
        compare_field(test, "length", ln, int'(snake_length), bad);
        compare_field(test, "running", run, int'(running), bad);
        compare_field(test, "game_over", over, int'(game_over), bad);
        compare_field(test, "tick_ready", run, int'(tick_ready), bad); // At rest it waits while running
        finish_test(test, bad);
    endtask

    // New fruit strictly inside the border and off the head
    task automatic check_fruit(input string test);
        int bad;
        bad = 0;
        if (fruit.x < 7'd1 || fruit.x > cell_t'(`SNAKE_FIELD_W - 2) ||
            fruit.y < 7'd1 || fruit.y > cell_t'(`SNAKE_FIELD_H - 2)) begin
            $display("%s: fruit (%0d,%0d) is not inside the border", test, fruit.x, fruit.y);
            bad++;
        end
        if (fruit == head) begin
            $display("%s: fruit was placed on the head", test);
            bad++;
        end
        if (!tick_ready) begin
            $display("%s: the game is not ready for a tick", test);
            bad++;
        end
        finish_test(test, bad);
    endtask

    task automatic note_failure(input string test, input string what);
        $display("%s: %s", test, what);
        finish_test(test, 1);
    endtask

endmodule

`default_nettype wire

// File: testbench/snake_chk.sv
`timescale 1ns/1ns
`default_nettype none

`include "snake_defines.svh"

module snake_chk import snake_pkg::*; (
    input wire    clock_25,
    input wire    reset,
    input logic   running,
    input logic   game_over,
    input logic   tick_ready,
    input pos_t   head,
    input pos_t   fruit,
    input score_t score
);

    int assert_fails = 0;   // Read by the testbench at the end

    // Play stops on a collision and the head stays where it crashed
    game_over_holds: assert property (@(posedge clock_25) disable iff (!reset)
        game_over |-> (!running && $stable(head)))
        else begin
            $error("game_over with the game still running or the head moving");
            assert_fails++;
        end

    // Fruit is settled whenever a tick may be taken
    fruit_in_field: assert property (@(posedge clock_25) disable iff (!reset)
        tick_ready |-> (fruit.x < cell_t'(`SNAKE_FIELD_W) && fruit.y < cell_t'(`SNAKE_FIELD_H)))
        else begin
            $error("fruit outside the field at (%0d,%0d)", fruit.x, fruit.y);
            assert_fails++;
        end

    score_limit: assert property (@(posedge clock_25) disable iff (!reset)
        score <= score_t'(`SNAKE_SCORE_MAX))
        else begin
            $error("score %0d above limit", score);
            assert_fails++;
        end

endmodule

`default_nettype wire

// File: hdl/snake_game.sv
`timescale 1ns/1ns
`default_nettype none

module snake_game import snake_pkg::*; (
    input  wire    clock_25,
    input  wire    reset,
    input  wire    game_tik,
    input  wire    turn_right,
    input  wire    turn_left,
    output pos_t   head,
    output pos_t   fruit,
    output score_t score,
    output len_t   snake_length,
    output logic   running,
    output logic   game_over,
    output logic   tick_ready
);

    game_cmd_t cmd;
    dir_t      dir;
    logic      turn_enable;
    logic      crash;
    logic      eaten;
    logic      fruit_on_snake;
    logic      fruit_retry;

    game_control u_control (
        .clock_25(clock_25),
        .reset(reset),
        .game_tik(game_tik),
        .turn_right(turn_right),
        .turn_left(turn_left),
        .crash(crash),
        .eaten(eaten),
        .fruit_retry(fruit_retry),
        .cmd(cmd),
        .turn_enable(turn_enable),
        .running(running),
        .game_over(game_over),
        .tick_ready(tick_ready)
    );

    steering u_steering (
        .clock_25(clock_25),
        .reset(reset),
        .cmd(cmd),
        .turn_right(turn_right),
        .turn_left(turn_left),
        .turn_enable(turn_enable),
        .dir(dir)
    );

    snake_body u_body (
        .clock_25(clock_25),
        .reset(reset),
        .cmd(cmd),
        .dir(dir),
        .fruit(fruit),
        .snake_length(snake_length),
        .head(head),
        .crash(crash),
        .eaten(eaten),
        .fruit_on_snake(fruit_on_snake)
    );

    fruit_score u_fruit (
        .clock_25(clock_25),
        .reset(reset),
        .cmd(cmd),
        .fruit_on_snake(fruit_on_snake),
        .fruit(fruit),
        .score(score),
        .snake_length(snake_length),
        .fruit_retry(fruit_retry)
    );

endmodule

`default_nettype wire

// File: hdl/fruit_score.sv
`timescale 1ns/1ns
`default_nettype none

`include "snake_defines.svh"

module fruit_score import snake_pkg::*; (
    input  wire       clock_25,
    input  wire       reset,
    input  game_cmd_t cmd,
    input  wire       fruit_on_snake,
    output pos_t      fruit,
    output score_t    score,
    output len_t      snake_length,
    output logic      fruit_retry
);

    localparam pos_t FRUIT_START = '{x: cell_t'(`SNAKE_FRUIT_X0), y: cell_t'(`SNAKE_FRUIT_Y0)};

    cell_t rnd_x;
    cell_t rnd_y;

    prbs7 #(
        .SEED(cell_t'(`SNAKE_SEED_X))
    ) prbs_x (
        .clock_25(clock_25),
        .reset(reset),
        .rnd(rnd_x)
    );

    prbs7 #(
        .SEED(cell_t'(`SNAKE_SEED_Y))
    ) prbs_y (
        .clock_25(clock_25),
        .reset(reset),
        .rnd(rnd_y)
    );

    // Fruit must sit strictly inside the border and off the snake
    assign fruit_retry = fruit_on_snake || (fruit.x == 7'd0) || (fruit.y == 7'd0)
                      || (fruit.x >= cell_t'(`SNAKE_FIELD_W - 1))
                      || (fruit.y >= cell_t'(`SNAKE_FIELD_H - 1));

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            fruit        <= FRUIT_START;
            score        <= '0;
            snake_length <= len_t'(`SNAKE_START_LEN);
        end else if (cmd.restart) begin
            fruit        <= FRUIT_START;
            score        <= '0;
            snake_length <= len_t'(`SNAKE_START_LEN);
        end else if (cmd.eat) begin
            fruit <= '{x: rnd_x, y: rnd_y};
            if (score == score_t'(`SNAKE_SCORE_MAX))
                score <= '0;
            else
                score <= score + 7'd1;
            if (snake_length != len_t'(`SNAKE_LEN_MAX - 1))    // Saturate at full length
                snake_length <= snake_length + len_t'(1);
        end else if (cmd.regen && fruit_retry) begin
            fruit <= '{x: rnd_x, y: rnd_y};
        end
    end

endmodule

`default_nettype wire

// File: hdl/snake_body.sv
`timescale 1ns/1ns
`default_nettype none

`include "snake_defines.svh"

module snake_body import snake_pkg::*; (
    input  wire       clock_25,
    input  wire       reset,
    input  game_cmd_t cmd,
    input  dir_t      dir,
    input  pos_t      fruit,
    input  len_t      snake_length,
    output pos_t      head,
    output logic      crash,
    output logic      eaten,
    output logic      fruit_on_snake
);

    localparam int   SLOTS     = `SNAKE_LEN_MAX - 1;
    localparam pos_t START_POS = '{x: cell_t'(`SNAKE_START_X), y: cell_t'(`SNAKE_START_Y)};
    localparam pos_t EMPTY_POS = '{x: cell_t'(`SNAKE_EMPTY_CELL), y: cell_t'(`SNAKE_EMPTY_CELL)};

    pos_t           body [SLOTS];   // Slot 0 sits right behind the head
    pos_t           head_next;
    logic           at_wall;        // Head is against the wall it faces
    logic [SLOTS-1:0] body_hit;
    logic [SLOTS-1:0] fruit_hit;

    always_comb begin
        head_next = head;
        at_wall   = 1'b0;
        case (dir)
            dir_right: begin
                if (head.x < cell_t'(`SNAKE_FIELD_W - 1))
                    head_next.x = head.x + 7'd1;
                else
                    at_wall = 1'b1;
            end
            dir_down: begin
                if (head.y < cell_t'(`SNAKE_FIELD_H - 1))
                    head_next.y = head.y + 7'd1;
                else
                    at_wall = 1'b1;
            end
            dir_left: begin
                if (head.x > 7'd0)
                    head_next.x = head.x - 7'd1;
                else
                    at_wall = 1'b1;
            end
            default: begin                              // Up
                if (head.y > 7'd0)
                    head_next.y = head.y - 7'd1;
                else
                    at_wall = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            head <= START_POS;
        else if (cmd.restart)
            head <= START_POS;
        else if (cmd.move)
            head <= head_next;
    end

    always_ff @(posedge clock_25) begin
        if (cmd.restart) begin
            for (int i = 0; i < SLOTS; i++) begin
                if (i < `SNAKE_START_LEN - 1)
                    body[i] <= '{x: cell_t'(`SNAKE_START_X - 1 - i), y: START_POS.y};
                else
                    body[i] <= EMPTY_POS;
            end
        end else if (cmd.move) begin
            body[0] <= head;
            for (int i = 1; i < SLOTS; i++) begin
                if (i < int'(snake_length) - 1)     // Slots past the tail stay put
                    body[i] <= body[i-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            body_hit[i]  = (body[i] == head);
            fruit_hit[i] = (body[i] == fruit);
        end
    end

    assign crash          = at_wall || (|body_hit);
    assign eaten          = (head == fruit);
    assign fruit_on_snake = eaten || (|fruit_hit);

endmodule

`default_nettype wire

// File: hdl/steering.sv
`timescale 1ns/1ns
`default_nettype none

module steering import snake_pkg::*; (
    input  wire       clock_25,
    input  wire       reset,
    input  game_cmd_t cmd,
    input  wire       turn_right,
    input  wire       turn_left,
    input  wire       turn_enable,
    output dir_t      dir
);

    logic turn_cw;          // Pending clockwise turn
    logic turn_ccw;
    dir_t dir_base;         // Heading taken at the last move
    dir_t dir_want;

    // Latest press wins, both at once cancel
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end else if (cmd.restart) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end else if (turn_enable && (turn_right || turn_left)) begin
            turn_cw  <= turn_right && !turn_left;
            turn_ccw <= turn_left && !turn_right;
        end else if (cmd.move) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end
    end

    always_comb begin
        if (turn_cw)
            dir_want = dir_t'(dir_base + 2'd1);
        else if (turn_ccw)
            dir_want = dir_t'(dir_base - 2'd1);
        else
            dir_want = dir_base;
    end

    // One rotation per pending turn, folded into the base on move
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            dir_base <= dir_right;
            dir      <= dir_right;
        end else if (cmd.restart) begin
            dir_base <= dir_right;
            dir      <= dir_right;
        end else begin
            if (cmd.move)
                dir_base <= dir_want;
            dir <= dir_want;
        end
    end

endmodule

`default_nettype wire

// File: hdl/game_control.sv
`timescale 1ns/1ns
`default_nettype none

module game_control import snake_pkg::*; (
    input  wire       clock_25,
    input  wire       reset,
    input  wire       game_tik,
    input  wire       turn_right,
    input  wire       turn_left,
    input  wire       crash,
    input  wire       eaten,
    input  wire       fruit_retry,
    output game_cmd_t cmd,
    output logic      turn_enable,
    output logic      running,
    output logic      game_over,
    output logic      tick_ready
);

    game_state_t state;
    game_state_t state_next;
    logic        button;

    assign button = turn_right || turn_left;    // Either button starts or restarts

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            state <= st_reset_idle;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            st_reset_idle:   state_next = st_idle;
            st_idle:         if (button) state_next = st_wait;
            st_wait:         if (game_tik) state_next = st_moving;
            st_moving:       state_next = st_move_done;
            st_move_done: begin
                if (crash)
                    state_next = st_collision;
                else if (eaten)
                    state_next = st_eaten;
                else
                    state_next = st_wait;
            end
            st_eaten:        state_next = st_fruit_update;
            st_fruit_update: if (!fruit_retry) state_next = st_wait;   // Retry until fruit is clear
            st_collision:    if (button) state_next = st_reset_idle;
            default:         state_next = st_reset_idle;
        endcase
    end

    // Moore outputs
    always_comb begin
        cmd.restart = (state == st_reset_idle);
        cmd.move    = (state == st_moving);
        cmd.eat     = (state == st_eaten);
        cmd.regen   = (state == st_fruit_update);
        tick_ready  = (state == st_wait);
        game_over   = (state == st_collision);
        running     = (state == st_wait) || (state == st_moving) || (state == st_move_done)
                   || (state == st_eaten) || (state == st_fruit_update);
        turn_enable = running;      // Idle presses only start the game
    end

endmodule

`default_nettype wire

// File: hdl/prbs7.sv
`timescale 1ns/1ns
`default_nettype none

// Fibonacci LFSR with polynomial x^7 + x^6 + 1
module prbs7 import snake_pkg::*; #(
    parameter cell_t SEED = 7'h01       // Must not be zero
) (
    input  wire   clock_25,
    input  wire   reset,
    output cell_t rnd
);

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            rnd <= SEED;
        else
            rnd <= {rnd[5:0], rnd[6] ^ rnd[5]};
    end

endmodule

`default_nettype wire

// File: hdl/snake_pkg.sv
`default_nettype none

`include "snake_defines.svh"

package snake_pkg;

    typedef logic [6:0] cell_t;                     // One grid coordinate
    typedef logic [`SNAKE_LEN_BITS-1:0] len_t;
    typedef logic [6:0] score_t;

    typedef struct packed {
        cell_t x;
        cell_t y;
    } pos_t;

    // Clockwise order so that a turn is a step of one
    typedef enum logic [1:0] {
        dir_right = 2'd0,
        dir_down  = 2'd1,
        dir_left  = 2'd2,
        dir_up    = 2'd3
    } dir_t;

    typedef enum logic [2:0] {
        st_reset_idle,
        st_idle,
        st_wait,
        st_moving,
        st_move_done,
        st_eaten,
        st_fruit_update,
        st_collision
    } game_state_t;

    // Strobes from the game controller
    typedef struct packed {
        logic restart;
        logic move;
        logic eat;
        logic regen;
    } game_cmd_t;

endpackage

`default_nettype wire

// File: hdl/snake_defines.svh
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// Playing field in cells including the border
`define SNAKE_FIELD_W       124
`define SNAKE_FIELD_H       81

// Head plus up to 31 body slots
`define SNAKE_LEN_BITS      5
`define SNAKE_LEN_MAX       32
`define SNAKE_START_LEN     6   // Length after reset or restart

// Head start cell with the body trailing to its left
`define SNAKE_START_X       8
`define SNAKE_START_Y       40

`define SNAKE_FRUIT_X0      18  // First fruit
`define SNAKE_FRUIT_Y0      50

`define SNAKE_SCORE_MAX     99  // Score wraps to 0 after this

// PRBS start values for the fruit generators
`define SNAKE_SEED_X        7'h1C
`define SNAKE_SEED_Y        7'h30

// Marker for body slots not yet in use
`define SNAKE_EMPTY_CELL    127

`endif
